//--- list.f
+incdir+logic
logic/hps_cmd_pkg.sv
logic/video_pkg.sv
logic/hps_cmd_decoder.sv
logic/umuldiv.sv
logic/ar_window_calc.sv
logic/sync_polarity_fix.sv
logic/vga_sync_out.sv
logic/video_ctrl_top.sv
tb/video_ctrl_checker.sv
tb/video_ctrl_tb.sv

//--- Bender.yml
package:
  name: video_ctrl

export_include_dirs:
  - logic

sources:
  - files:
      - logic/hps_cmd_pkg.sv
      - logic/video_pkg.sv
      - logic/hps_cmd_decoder.sv
      - logic/umuldiv.sv
      - logic/ar_window_calc.sv
      - logic/sync_polarity_fix.sv
      - logic/vga_sync_out.sv
      - logic/video_ctrl_top.sv
  - target: test
    files:
      - tb/video_ctrl_checker.sv
      - tb/video_ctrl_tb.sv

//--- tb/video_ctrl_tb.sv
// Video control testbench
// Programs the host link from a table of timings, limits and aspect
// ratios, checks the computed window, then drives raw sync lines
// through both polarities, hs_neg and composite sync

`include "video_ctrl_consts.svh"

module video_ctrl_tb;

	import hps_cmd_pkg::*;
	import video_pkg::*;

	localparam int N_ROWS        = 9;
	localparam int ROW_CYCLES    = 400;
	localparam int SETTLE_CYCLES = 300;
	localparam int STROBE_CYCLES = 4;
	localparam int N_LINES       = 24;
	localparam int SETTLE_LINES  = 4;
	localparam int LINE_BASE     = 80;
	localparam int HS_WIDTH      = 8;
	localparam int SYNC_CYCLES   = 4 * (N_LINES * (LINE_BASE + 8) + 200);
	localparam int WATCHDOG_CYCLES = 10 + N_ROWS * ROW_CYCLES + SYNC_CYCLES;

	typedef struct packed {
		video_timing_t        timing;
		video_limit_t         limit;
		ar_custom_t           arc;
		logic [`VC_AR_W-1:0]  arx;
		logic [`VC_AR_W-1:0]  ary;
		logic [`VC_DIM_W-1:0] exp_w;
		logic [`VC_DIM_W-1:0] exp_h;
		video_window_t        exp_win;
	} ar_row_t;

	logic                 clk_sys;
	logic                 resetd;
	logic                 io_uio;
	logic                 io_clk;
	logic [`VC_IO_DW-1:0] io_din;
	logic [`VC_AR_W-1:0]  arx_in;
	logic [`VC_AR_W-1:0]  ary_in;
	logic                 hs_raw;
	logic                 vs_raw;
	logic                 o_io_ack;
	logic [`VC_DIM_W-1:0] o_hdmi_width;
	logic [`VC_DIM_W-1:0] o_hdmi_height;
	video_window_t        o_win;
	logic                 o_vga_hs;
	logic                 o_vga_vs;

	ar_row_t              rows [N_ROWS];
	logic [`VC_IO_DW-1:0] cmd_words [8];
	integer               seed;
	int                   err_cnt;

	video_ctrl_top DUT (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_io_uio      (io_uio),
		.i_io_clk      (io_clk),
		.i_io_din      (io_din),
		.i_arx         (arx_in),
		.i_ary         (ary_in),
		.i_hs_raw      (hs_raw),
		.i_vs_raw      (vs_raw),
		.o_io_ack      (o_io_ack),
		.o_hdmi_width  (o_hdmi_width),
		.o_hdmi_height (o_hdmi_height),
		.o_win         (o_win),
		.o_vga_hs      (o_vga_hs),
		.o_vga_vs      (o_vga_vs)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	function automatic ar_row_t make_row(input int w, h, vset, hset, fs, ax, ay,
		input int c1x, c1y, c2x, c2y, ew, eh, hmin, hmax, vmin, vmax);
		ar_row_t r;
		r.timing.width    = 12'(w);
		r.timing.height   = 12'(h);
		r.timing.hs_neg   = 1'b0;
		r.timing.vs_neg   = 1'b0;
		r.limit.vset      = 12'(vset);
		r.limit.hset      = 12'(hset);
		r.limit.freescale = fs[0];
		r.arc.arc1x       = 13'(c1x);
		r.arc.arc1y       = 13'(c1y);
		r.arc.arc2x       = 13'(c2x);
		r.arc.arc2y       = 13'(c2y);
		r.arx             = 13'(ax);
		r.ary             = 13'(ay);
		r.exp_w           = 12'(ew);
		r.exp_h           = 12'(eh);
		r.exp_win.hmin    = 12'(hmin);
		r.exp_win.hmax    = 12'(hmax);
		r.exp_win.vmin    = 12'(vmin);
		r.exp_win.vmax    = 12'(vmax);
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Host link
	////////////////////////////////////////////////////////////

	// Ack must follow each host clock edge two cycles later
	task automatic send_word(input logic [`VC_IO_DW-1:0] word);
		int n;
		io_din = word;
		io_clk = 1'b1;
		n = 0;
		while (o_io_ack !== 1'b1 && n < 8) begin
			next_cycle();
			n++;
		end
		check_value("o_io_ack rise delay", n, 2);
		while (n < STROBE_CYCLES) begin
			next_cycle();
			n++;
		end
		io_clk = 1'b0;
		n = 0;
		while (o_io_ack !== 1'b0 && n < 8) begin
			next_cycle();
			n++;
		end
		check_value("o_io_ack fall delay", n, 2);
	endtask

	task automatic send_cmd(input hps_opcode_e op, input int n_words);
		int i;
		io_uio = 1'b1;
		next_cycle();
		send_word({8'h00, op});
		for (i = 0; i < n_words; i++) begin
			send_word(cmd_words[i]);
		end
		io_uio = 1'b0;
		next_cycle();
	endtask

	// Porch and sync length words only fill their slots
	task automatic send_timing(input video_timing_t t);
		cmd_words[0] = {4'h0, t.width};
		cmd_words[1] = 16'd88;
		cmd_words[2] = {t.hs_neg, 15'd44};
		cmd_words[3] = 16'd148;
		cmd_words[4] = {4'h0, t.height};
		cmd_words[5] = 16'd4;
		cmd_words[6] = {t.vs_neg, 15'd5};
		cmd_words[7] = 16'd36;
		send_cmd(OP_VIDEO_TIMING, 8);
	endtask

	task automatic apply_row(input ar_row_t r);
		arx_in = r.arx;
		ary_in = r.ary;
		send_timing(r.timing);
		cmd_words[0] = {4'h0, r.limit.vset};
		send_cmd(OP_VSET, 1);
		cmd_words[0] = {r.limit.freescale, 3'b000, r.limit.hset};
		send_cmd(OP_HSET_FREESCALE, 1);
		cmd_words[0] = {3'b000, r.arc.arc1x};
		cmd_words[1] = {3'b000, r.arc.arc1y};
		cmd_words[2] = {3'b000, r.arc.arc2x};
		cmd_words[3] = {3'b000, r.arc.arc2y};
		send_cmd(OP_AR_CUSTOM, 4);
	endtask

	task automatic check_row(input ar_row_t r, input int idx);
		check_value($sformatf("row %0d o_hdmi_width", idx), o_hdmi_width, r.exp_w);
		check_value($sformatf("row %0d o_hdmi_height", idx), o_hdmi_height, r.exp_h);
		check_value($sformatf("row %0d o_win.hmin", idx), o_win.hmin, r.exp_win.hmin);
		check_value($sformatf("row %0d o_win.hmax", idx), o_win.hmax, r.exp_win.hmax);
		check_value($sformatf("row %0d o_win.vmin", idx), o_win.vmin, r.exp_win.vmin);
		check_value($sformatf("row %0d o_win.vmax", idx), o_win.vmax, r.exp_win.vmax);
	endtask

	////////////////////////////////////////////////////////////
	// Sync lines
	////////////////////////////////////////////////////////////

	// Composite sync adds one register, so it compares two cycles back
	task automatic run_lines(input int n_lines, input bit neg_raw, input bit csync_mode,
		input bit hs_neg, input bit vs_neg);
		int  line;
		int  c;
		int  len;
		bit  pulse;
		bit  d1;
		bit  d2;
		bit  vs_line;
		bit  exp_hs;
		d1 = 1'b0;
		d2 = 1'b0;
		for (line = 0; line < n_lines; line++) begin
			len = LINE_BASE + ($random(seed) & 7);
			vs_line = csync_mode && (line % 12 < 3);
			for (c = 0; c < len; c++) begin
				pulse  = (c < HS_WIDTH);
				hs_raw = pulse ^ neg_raw;
				vs_raw = vs_line;
				if (line >= SETTLE_LINES) begin
					exp_hs = ~(csync_mode ? d2 : d1) ^ hs_neg;
					if (!csync_mode || line % 12 > 3) begin
						check_value("o_vga_hs", o_vga_hs, exp_hs);
					end
					check_value("o_vga_vs", o_vga_vs, !vs_neg);
				end
				d2 = d1;
				d1 = pulse;
				next_cycle();
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int            i;
		video_timing_t sync_timing;
		seed    = 32'hdf35_7a03;
		err_cnt = 0;
		resetd  = 1'b1;
		io_uio  = 1'b0;
		io_clk  = 1'b0;
		io_din  = '0;
		arx_in  = '0;
		ary_in  = '0;
		hs_raw  = 1'b0;
		vs_raw  = 1'b0;

		// Every row keeps the 1920 reset width
		rows[0] = make_row(1920, 720, 0, 0, 1, 4, 3, 5, 4, 3, 2,
			1920, 720, 0, 1919, 0, 719);
		rows[1] = make_row(1920, 720, 0, 0, 0, 4, 3, 5, 4, 3, 2,
			1920, 720, 480, 1439, 0, 719);
		rows[2] = make_row(1920, 1080, 0, 0, 0, 4, 3, 5, 4, 3, 2,
			1920, 1080, 240, 1679, 0, 1079);
		rows[3] = make_row(1920, 1080, 0, 0, 0, 16, 9, 5, 4, 3, 2,
			1920, 1080, 0, 1919, 0, 1079);
		rows[4] = make_row(1920, 1080, 720, 1280, 0, 16, 9, 5, 4, 3, 2,
			1280, 720, 320, 1599, 180, 899);
		rows[5] = make_row(1920, 1080, 0, 0, 0, 1, 0, 5, 4, 3, 2,
			1920, 1080, 285, 1634, 0, 1079);
		rows[6] = make_row(1920, 1080, 0, 0, 0, 2, 0, 5, 4, 3, 2,
			1920, 1080, 150, 1769, 0, 1079);
		// Direct 800x600 through custom ratio 1
		rows[7] = make_row(1920, 1080, 0, 0, 0, 1, 0, 'h1320, 'h1258, 3, 2,
			1920, 1080, 560, 1359, 240, 839);
		// Direct 2000x500 from the core, clamped to the width
		rows[8] = make_row(1920, 1080, 720, 0, 0, 'h17D0, 'h11F4, 5, 4, 3, 2,
			1920, 720, 0, 1919, 290, 789);

		repeat (3) @(posedge clk_sys);
		#2;
		resetd = 1'b0;
		check_value("o_io_ack after reset", o_io_ack, 0);

		for (i = 0; i < N_ROWS; i++) begin
			apply_row(rows[i]);
			repeat (SETTLE_CYCLES) next_cycle();
			check_row(rows[i], i);
		end

		sync_timing.width  = 12'd1920;
		sync_timing.height = 12'd1080;
		sync_timing.hs_neg = 1'b0;
		sync_timing.vs_neg = 1'b0;
		run_lines(N_LINES, 1'b0, 1'b0, 1'b0, 1'b0);
		run_lines(N_LINES, 1'b1, 1'b0, 1'b0, 1'b0);

		sync_timing.hs_neg = 1'b1;
		send_timing(sync_timing);
		run_lines(N_LINES, 1'b1, 1'b0, 1'b1, 1'b0);

		sync_timing.hs_neg = 1'b0;
		sync_timing.vs_neg = 1'b1;
		send_timing(sync_timing);
		cmd_words[0] = 16'h0008;
		send_cmd(OP_CFG, 1);
		run_lines(N_LINES, 1'b0, 1'b1, 1'b0, 1'b1);

		$display("Errors: %0d testbench checks, %0d assertion failures",
			err_cnt, DUT.u_checker.fail_cnt);
		if (err_cnt == 0 && DUT.u_checker.fail_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- tb/video_ctrl_checker.sv
// Video control assertions
// Acknowledge timing and display window sanity, bound into
// the top level

module video_ctrl_checker (
	input logic                     clk_sys,
	input logic                     resetd,
	input logic                     i_io_clk,
	input logic                     i_io_ack,
	input video_pkg::video_window_t i_win,
	input video_pkg::video_timing_t i_timing
);

	int fail_cnt = 0;

	// Two stage acknowledge
	assert property (@(posedge clk_sys) disable iff (resetd)
		i_io_ack == $past(i_io_clk, 2))
	else begin
		$error("Acknowledge does not follow the host clock by two cycles");
		fail_cnt++;
	end

	assert property (@(posedge clk_sys) disable iff (resetd)
		(i_win.hmax != '0) |-> (i_win.hmin <= i_win.hmax))
	else begin
		$error("Window hmin lies above hmax");
		fail_cnt++;
	end

	assert property (@(posedge clk_sys) disable iff (resetd)
		i_win.hmax < i_timing.width)
	else begin
		$error("Window hmax reaches past the output width");
		fail_cnt++;
	end

endmodule

bind video_ctrl_top video_ctrl_checker u_checker (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.i_io_clk (i_io_clk),
	.i_io_ack (o_io_ack),
	.i_win    (o_win),
	.i_timing (timing)
);

//--- logic/video_ctrl_top.sv
// Video control top level
// Host command decoder, aspect ratio window calculator and the
// VGA sync path on one system clock

`include "video_ctrl_consts.svh"

module video_ctrl_top (
	input  logic                     clk_sys,
	input  logic                     resetd,
	input  logic                     i_io_uio,
	input  logic                     i_io_clk,
	input  logic [`VC_IO_DW-1:0]     i_io_din,
	input  logic [`VC_AR_W-1:0]      i_arx,
	input  logic [`VC_AR_W-1:0]      i_ary,
	input  logic                     i_hs_raw,
	input  logic                     i_vs_raw,
	output logic                     o_io_ack,
	output logic [`VC_DIM_W-1:0]     o_hdmi_width,
	output logic [`VC_DIM_W-1:0]     o_hdmi_height,
	output video_pkg::video_window_t o_win,
	output logic                     o_vga_hs,
	output logic                     o_vga_vs
);

	import video_pkg::*;

	video_timing_t timing;
	video_limit_t  limit;
	ar_custom_t    ar_custom;
	logic          csync_en;
	logic          hs_fix, vs_fix;

	hps_cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_clk    (i_io_clk),
		.i_io_din    (i_io_din),
		.o_io_ack    (o_io_ack),
		.o_timing    (timing),
		.o_limit     (limit),
		.o_ar_custom (ar_custom),
		.o_csync_en  (csync_en)
	);

	ar_window_calc u_ar_calc (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_timing      (timing),
		.i_limit       (limit),
		.i_ar_custom   (ar_custom),
		.i_arx         (i_arx),
		.i_ary         (i_ary),
		.o_hdmi_width  (o_hdmi_width),
		.o_hdmi_height (o_hdmi_height),
		.o_win         (o_win)
	);

	sync_polarity_fix u_hs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs_raw),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix u_vs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs_raw),
		.o_sync  (vs_fix)
	);

	vga_sync_out u_vga_sync (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_hs       (hs_fix),
		.i_vs       (vs_fix),
		.i_timing   (timing),
		.i_csync_en (csync_en),
		.o_vga_hs   (o_vga_hs),
		.o_vga_vs   (o_vga_vs)
	);

endmodule

//--- logic/vga_sync_out.sv
// VGA sync output stage
// Builds composite sync from active high hs and vs, then picks
// and polarizes the analog VGA sync pins

`include "video_ctrl_consts.svh"

module vga_sync_out (
	input  logic                     clk_sys,
	input  logic                     resetd,
	input  logic                     i_hs,
	input  logic                     i_vs,
	input  video_pkg::video_timing_t i_timing,
	input  logic                     i_csync_en,
	output logic                     o_vga_hs,
	output logic                     o_vga_vs
);

	logic                      prev_hs;
	logic                      cs_hs, cs_vs, csync;
	logic [`VC_SYNC_CNT_W-1:0] h_cnt, line_len, hs_len;

	// During vsync the hsync pulse moves one pulse width earlier
	assign csync = cs_hs ^ cs_vs;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			o_vga_hs <= 1'b0;
			o_vga_vs <= 1'b0;
		end else begin
			h_cnt   <= h_cnt + 1'd1;
			prev_hs <= i_hs;
			if (prev_hs != i_hs) begin
				h_cnt <= '0;
				if (i_hs) begin
					line_len <= h_cnt - hs_len;
					cs_hs    <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end
			if (!i_vs) cs_hs <= i_hs;
			else if (h_cnt == line_len) cs_hs <= 1'b1;
			cs_vs <= i_vs;

			o_vga_hs <= (i_csync_en ? ~csync : ~i_hs) ^ i_timing.hs_neg;
			o_vga_vs <= (~i_vs | i_csync_en) ^ i_timing.vs_neg;
		end
	end

endmodule

//--- logic/sync_polarity_fix.sv
// Sync polarity correction
// Measures the high and low time of a raw sync and inverts it
// when high is the longer phase, so the output is active high

`include "video_ctrl_consts.svh"

module sync_polarity_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                      s1, s2;
	logic                      pol;
	logic [`VC_SYNC_CNT_W-1:0] cnt;
	logic [`VC_SYNC_CNT_W-1:0] high_len, low_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Rising edge closes a low phase, falling edge a high one
			if (!s2 && s1) low_len  <= cnt;
			if (s2 && !s1) high_len <= cnt;
			if (s2 != s1) begin
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'd1;
			end
			pol <= high_len > low_len;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

//--- logic/ar_window_calc.sv
// Aspect ratio window calculator
// Limits the output size by the host VSET/HSET values, picks the
// core or a custom aspect ratio, scales it through a shared
// multiply-divide unit and centers the result on the output

`include "video_ctrl_consts.svh"

module ar_window_calc (
	input  logic                      clk_sys,
	input  logic                      resetd,
	input  video_pkg::video_timing_t  i_timing,
	input  video_pkg::video_limit_t   i_limit,
	input  video_pkg::ar_custom_t     i_ar_custom,
	input  logic [`VC_AR_W-1:0]       i_arx,
	input  logic [`VC_AR_W-1:0]       i_ary,
	output logic [`VC_DIM_W-1:0]      o_hdmi_width,
	output logic [`VC_DIM_W-1:0]      o_hdmi_height,
	output video_pkg::video_window_t  o_win
);

	import video_pkg::*;

	ar_calc_state_e       state;
	logic [`VC_DIM_W-1:0] lim_w, lim_h;
	logic [`VC_DIM_W-1:0] arx, ary;
	logic                 direct;
	logic                 md_start, md_busy;
	logic [`VC_DIM_W-1:0] md_mul1, md_mul2, md_div, md_res;
	logic [`VC_DIM_W-1:0] wcalc, hcalc, vid_w, vid_h;
	logic [`VC_DIM_W-1:0] cw, ch, hoff, voff;
	video_window_t        win;

	umuldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	////////////////////////////////////////////////////////////
	// Limited size and ratio selection
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		lim_h <= (i_limit.vset != '0 && i_limit.vset < i_timing.height) ?
		         i_limit.vset : i_timing.height;
		lim_w <= (i_limit.hset != '0 && i_limit.hset < i_timing.width) ?
		         i_limit.hset : i_timing.width;

		if (i_ary == '0) begin
			if (i_arx == `VC_AR_W'd1) begin
				arx    <= i_ar_custom.arc1x[`VC_DIM_W-1:0];
				ary    <= i_ar_custom.arc1y[`VC_DIM_W-1:0];
				direct <= i_ar_custom.arc1x[`VC_AR_W-1] | i_ar_custom.arc1y[`VC_AR_W-1];
			end else if (i_arx == `VC_AR_W'd2) begin
				arx    <= i_ar_custom.arc2x[`VC_DIM_W-1:0];
				ary    <= i_ar_custom.arc2y[`VC_DIM_W-1:0];
				direct <= i_ar_custom.arc2x[`VC_AR_W-1] | i_ar_custom.arc2y[`VC_AR_W-1];
			end else begin
				arx    <= '0;
				ary    <= '0;
				direct <= 1'b0;
			end
		end else begin
			arx    <= i_arx[`VC_DIM_W-1:0];
			ary    <= i_ary[`VC_DIM_W-1:0];
			direct <= i_arx[`VC_AR_W-1] | i_ary[`VC_AR_W-1];
		end
	end

	// Guard against a width change landing mid pass
	assign cw   = (vid_w > i_timing.width)  ? i_timing.width  : vid_w;
	assign ch   = (vid_h > i_timing.height) ? i_timing.height : vid_h;
	assign hoff = (i_timing.width  - cw) >> 1;
	assign voff = (i_timing.height - ch) >> 1;

	////////////////////////////////////////////////////////////
	// Calculator FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= ST_SELECT;
			md_start <= 1'b0;
			win      <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				ST_SELECT: begin
					if (i_limit.freescale || arx == '0 || ary == '0) begin
						wcalc <= lim_w;
						hcalc <= lim_h;
						state <= ST_CLAMP;
					end else if (direct) begin
						wcalc <= arx;
						hcalc <= ary;
						state <= ST_CLAMP;
					end else begin
						state <= ST_W_START;
					end
				end
				ST_W_START: begin
					md_mul1  <= lim_h;
					md_mul2  <= arx;
					md_div   <= ary;
					md_start <= 1'b1;
					state    <= ST_W_WAIT;
				end
				// Busy rises one cycle after start
				ST_W_WAIT: if (!md_start && !md_busy) begin
					wcalc <= md_res;
					state <= ST_H_START;
				end
				ST_H_START: begin
					md_mul1  <= lim_w;
					md_mul2  <= ary;
					md_div   <= arx;
					md_start <= 1'b1;
					state    <= ST_H_WAIT;
				end
				ST_H_WAIT: if (!md_start && !md_busy) begin
					hcalc <= md_res;
					state <= ST_CLAMP;
				end
				ST_CLAMP: begin
					vid_w <= (wcalc > lim_w) ? lim_w : wcalc;
					vid_h <= (hcalc > lim_h) ? lim_h : hcalc;
					state <= ST_CENTER;
				end
				default: begin
					win.hmin <= hoff;
					win.hmax <= hoff + cw - 1'd1;
					win.vmin <= voff;
					win.vmax <= voff + ch - 1'd1;
					state    <= ST_SELECT;
				end
			endcase
		end
	end

	assign o_hdmi_width  = lim_w;
	assign o_hdmi_height = lim_h;
	assign o_win         = win;

endmodule

//--- logic/umuldiv.sv
// Sequential unsigned multiply then divide
// Computes mul1 * mul2 / div with one restoring division step
// per cycle, keeping the low bits of the quotient

`include "video_ctrl_consts.svh"

module umuldiv (
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  logic                 i_start,
	input  logic [`VC_DIM_W-1:0] i_mul1,
	input  logic [`VC_DIM_W-1:0] i_mul2,
	input  logic [`VC_DIM_W-1:0] i_div,
	output logic                 o_busy,
	output logic [`VC_DIM_W-1:0] o_result
);

	localparam int PW = 2 * `VC_DIM_W;

	logic [PW-1:0]        quo;
	logic [`VC_DIM_W-1:0] rem;
	logic [`VC_DIM_W-1:0] dv;
	logic [4:0]           bits_left;
	logic [`VC_DIM_W:0]   trial;

	// Next partial remainder before the subtract
	assign trial = {rem, quo[PW-1]};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy    <= 1'b0;
			bits_left <= '0;
		end else if (i_start) begin
			o_busy    <= 1'b1;
			bits_left <= 5'(PW);
		end else if (o_busy) begin
			bits_left <= bits_left - 1'd1;
			if (bits_left == 5'd1) begin
				o_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quo <= i_mul1 * i_mul2;
			rem <= '0;
			dv  <= i_div;
		end else if (o_busy) begin
			if (trial >= {1'b0, dv}) begin
				rem <= `VC_DIM_W'(trial - {1'b0, dv});
				quo <= {quo[PW-2:0], 1'b1};
			end else begin
				rem <= trial[`VC_DIM_W-1:0];
				quo <= {quo[PW-2:0], 1'b0};
			end
		end
	end

	assign o_result = quo[`VC_DIM_W-1:0];

endmodule

//--- logic/hps_cmd_decoder.sv
// Host command decoder
// Turns the level clocked host link into strobes, returns the
// two stage acknowledge, and parses opcodes and data words into
// the video timing, limit, custom ratio and sync config registers

`include "video_ctrl_consts.svh"

module hps_cmd_decoder (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_io_uio,
	input  logic                   i_io_clk,
	input  logic [`VC_IO_DW-1:0]   i_io_din,
	output logic                   o_io_ack,
	output video_pkg::video_timing_t o_timing,
	output video_pkg::video_limit_t  o_limit,
	output video_pkg::ar_custom_t    o_ar_custom,
	output logic                   o_csync_en
);

	import hps_cmd_pkg::*;
	import video_pkg::*;

	logic          rack;
	logic          strobe;
	logic          has_cmd;
	hps_opcode_e   cmd;
	logic [7:0]    cnt;
	hps_cfg_t      cfg;
	video_timing_t timing;
	video_limit_t  limit;
	ar_custom_t    arc;

	////////////////////////////////////////////////////////////
	// Strobe and acknowledge
	////////////////////////////////////////////////////////////

	// One cycle pulse on the first sample of a high host clock
	assign strobe = i_io_clk & ~rack;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			rack     <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	////////////////////////////////////////////////////////////
	// Command parser
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd     <= OP_NONE;
			cnt     <= '0;
			cfg     <= '0;
			timing  <= '{width: `VC_DEF_WIDTH, height: `VC_DEF_HEIGHT,
			             hs_neg: 1'b0, vs_neg: 1'b0};
			limit   <= '0;
			arc     <= '0;
		end else if (!i_io_uio) begin
			has_cmd <= 1'b0;
			cmd     <= OP_NONE;
		end else if (strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= hps_opcode_e'(i_io_din[`VC_CMD_W-1:0]);
				cnt     <= '0;
			end else begin
				// Saturate so long transfers never alias back into the slots
				if (cnt != 8'hFF) begin
					cnt <= cnt + 1'd1;
				end
				case (cmd)
					OP_CFG: cfg.csync_en <= i_io_din[3];
					OP_VIDEO_TIMING: begin
						// Porch and sync length words are skipped
						if (cnt < 8'd8) begin
							case (cnt[2:0])
								3'd0: timing.width  <= i_io_din[`VC_DIM_W-1:0];
								3'd2: timing.hs_neg <= i_io_din[15];
								3'd4: timing.height <= i_io_din[`VC_DIM_W-1:0];
								3'd6: timing.vs_neg <= i_io_din[15];
								default: ;
							endcase
						end
					end
					OP_VSET: limit.vset <= i_io_din[`VC_DIM_W-1:0];
					OP_HSET_FREESCALE: begin
						limit.freescale <= i_io_din[15];
						limit.hset      <= i_io_din[`VC_DIM_W-1:0];
					end
					OP_AR_CUSTOM: begin
						case (cnt)
							8'd0: arc.arc1x <= i_io_din[`VC_AR_W-1:0];
							8'd1: arc.arc1y <= i_io_din[`VC_AR_W-1:0];
							8'd2: arc.arc2x <= i_io_din[`VC_AR_W-1:0];
							8'd3: arc.arc2y <= i_io_din[`VC_AR_W-1:0];
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	assign o_timing    = timing;
	assign o_limit     = limit;
	assign o_ar_custom = arc;
	assign o_csync_en  = cfg.csync_en;

endmodule

//--- logic/video_pkg.sv
// Video geometry types
// Output timing, size limits, custom aspect ratios, the
// computed display window and the window calculator states

`include "video_ctrl_consts.svh"

package video_pkg;

	typedef struct packed {
		logic [`VC_DIM_W-1:0] width;
		logic [`VC_DIM_W-1:0] height;
		logic                 hs_neg;
		logic                 vs_neg;
	} video_timing_t;

	typedef struct packed {
		logic [`VC_DIM_W-1:0] vset;
		logic [`VC_DIM_W-1:0] hset;
		logic                 freescale;
	} video_limit_t;

	// Two host supplied ratios, selected by the core with ary of zero
	typedef struct packed {
		logic [`VC_AR_W-1:0] arc1x;
		logic [`VC_AR_W-1:0] arc1y;
		logic [`VC_AR_W-1:0] arc2x;
		logic [`VC_AR_W-1:0] arc2y;
	} ar_custom_t;

	typedef struct packed {
		logic [`VC_DIM_W-1:0] hmin;
		logic [`VC_DIM_W-1:0] hmax;
		logic [`VC_DIM_W-1:0] vmin;
		logic [`VC_DIM_W-1:0] vmax;
	} video_window_t;

	typedef enum logic [2:0] {
		ST_SELECT, ST_W_START, ST_W_WAIT, ST_H_START, ST_H_WAIT, ST_CLAMP, ST_CENTER
	} ar_calc_state_e;

endpackage

//--- logic/hps_cmd_pkg.sv
// Host command protocol types
// Opcodes accepted on the host link and the general
// configuration word written by the CFG command

`include "video_ctrl_consts.svh"

package hps_cmd_pkg;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [`VC_CMD_W-1:0] {
		OP_NONE           = 8'h00,
		OP_CFG            = 8'h01,
		OP_VIDEO_TIMING   = 8'h20,
		OP_VSET           = 8'h27,
		OP_HSET_FREESCALE = 8'h37,
		OP_AR_CUSTOM      = 8'h3A
	} hps_opcode_e;

	////////////////////////////////////////////////////////////
	// Configuration
	////////////////////////////////////////////////////////////

	// Only composite sync survives from the CFG word
	typedef struct packed {
		logic csync_en;
	} hps_cfg_t;

endpackage

//--- logic/video_ctrl_consts.svh
// Video control constants
// Host word and opcode widths, video dimension widths and
// the reset timing used until the host programs its own

`ifndef VIDEO_CTRL_CONSTS_SVH
`define VIDEO_CTRL_CONSTS_SVH

// Host link
`define VC_IO_DW 16
`define VC_CMD_W 8

// Pixel and line dimensions
`define VC_DIM_W 12

// Aspect ratio field, top bit flags a direct size
`define VC_AR_W 13

// Default mode is 1080p
`define VC_DEF_WIDTH 1920
`define VC_DEF_HEIGHT 1080

// Sync duration counters
`define VC_SYNC_CNT_W 16

`endif
